/* design/board_pkg.sv */
// Board-level button constants
// Default timing values for the pad board top level

package board_pkg;

    // Raw pins in order btn[0], btn[1], btn[2], btn_u
    localparam int num_buttons = 4;

    // Position of btn_u in the sampled vector
    localparam int btn_up_index = 3;

    // Stable cycles before a debounced button changes
    localparam int default_debounce_cycles = 16;

    // Half period of pad_clk and length of the latch pulse
    localparam int default_pad_half_period = 4;

    // Cycles between two gamepad reads
    localparam int default_poll_cycles = 256;

endpackage

/* design/pad_pkg.sv */
// Serial gamepad word definitions
// Packed union with raw and named views, button bit positions

package pad_pkg;

    // Serial word length
    localparam int pad_bits = 12;

    // Named buttons, bit 0 (b) is shifted out first
    typedef struct packed {
        logic r;
        logic l;
        logic x;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b;
    } pad_buttons_t;

    // One pad word, read as shift bits or as buttons
    typedef union packed {
        logic [pad_bits-1:0] raw;
        pad_buttons_t        btn;
    } pad_word_t;

    // Board button positions in the pad word
    localparam int pad_bit_b     = 0;
    localparam int pad_bit_start = 3;
    localparam int pad_bit_a     = 8;

endpackage

/* design/button_sampler.sv */
// Two-stage synchronizer for the raw board button pins

`timescale 1ns/1ns

module button_sampler
    import board_pkg::*;
(
    input  logic                   clk_2x,
    input  logic                   rst,

    input  logic [num_buttons-1:0] pins,
    output logic [num_buttons-1:0] btn_sync
);

    // First stage may go metastable
    logic [num_buttons-1:0] sync_q1;

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            sync_q1 <= '0;
        end else begin
            sync_q1 <= pins;
        end
    end

    // Second stage gives a settled level
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            btn_sync <= '0;
        end else begin
            btn_sync <= sync_q1;
        end
    end

endmodule

/* design/button_debounce.sv */
// Stable-count debouncer for a single button
// Output follows the input only after it held steady long enough

`timescale 1ns/1ns

module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic clk_2x,
    input  logic rst,

    input  logic btn_in,
    output logic btn_out
);

    localparam int cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

    // Cycles the input has differed from the output
    logic [cnt_w-1:0] count;

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            count   <= '0;
            btn_out <= 1'b0;
        end else if (btn_in == btn_out) begin
            // Any glitch back to the old level restarts the count
            count <= '0;
        end else if (count == cnt_w'(DEBOUNCE_CYCLES - 1)) begin
            btn_out <= btn_in;
            count   <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* design/mock_gamepad.sv */
// Mock serial gamepad built from three debounced board buttons
// Latch loads the word, each pad_clk rise shifts out the next bit

`timescale 1ns/1ns

module mock_gamepad
    import pad_pkg::*;
(
    input  logic       clk_2x,
    input  logic       rst,

    input  logic       pad_clk,
    input  logic       pad_latch,
    input  logic [2:0] pad_btn,

    output logic       pad_out
);

    pad_word_t           pad_word;
    logic [pad_bits-1:0] shift_reg;
    logic                pad_clk_q;

    // Active low word, unused buttons idle high
    always_comb begin
        pad_word           = '1;
        pad_word.btn.a     = ~pad_btn[0];
        pad_word.btn.b     = ~pad_btn[1];
        pad_word.btn.start = ~pad_btn[2];
    end

    // Edge detect on the incoming pad clock
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_clk_q <= 1'b0;
        end else begin
            pad_clk_q <= pad_clk;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            shift_reg <= '1;
        end else if (pad_latch) begin
            shift_reg <= pad_word.raw;
        end else if (pad_clk && !pad_clk_q) begin
            // Reads past the last bit see released buttons
            shift_reg <= {1'b1, shift_reg[pad_bits-1:1]};
        end
    end

    assign pad_out = shift_reg[0];

endmodule

/* design/gamepad_reader.sv */
// Periodic serial gamepad poller for two controller ports
// Drives latch and clock, shifts in both ports, publishes button state and LEDs

`timescale 1ns/1ns

module gamepad_reader
    import pad_pkg::*;
#(
    parameter int PAD_HALF_PERIOD = 4,
    parameter int POLL_CYCLES     = 256
) (
    input  logic      clk_2x,
    input  logic      rst,

    input  logic      pad_data0,
    input  logic      pad_data1,

    output logic      pad_latch,
    output logic      pad_clk,

    output pad_word_t pad_state0,
    output pad_word_t pad_state1,
    output logic      pad_valid,

    output logic      led_r,
    output logic      led_b
);

    localparam int poll_w  = $clog2(POLL_CYCLES);
    localparam int phase_w = $clog2(PAD_HALF_PERIOD + 1);
    localparam int bit_w   = $clog2(pad_bits);

    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_latch    = 2'd1;
    localparam logic [1:0] st_clk_low  = 2'd2;
    localparam logic [1:0] st_clk_high = 2'd3;

    logic [1:0]         state;
    logic [poll_w-1:0]  poll_cnt;
    logic [phase_w-1:0] phase_cnt;
    logic [bit_w-1:0]   bit_cnt;
    logic               phase_done;

    // Collected serial words, still active low
    pad_word_t shift0;
    pad_word_t shift1;

    assign phase_done = (phase_cnt == phase_w'(PAD_HALF_PERIOD - 1));

    // Free running poll timer
    always_ff @(posedge clk_2x) begin
        if (rst || poll_cnt == poll_w'(POLL_CYCLES - 1)) begin
            poll_cnt <= '0;
        end else begin
            poll_cnt <= poll_cnt + 1'b1;
        end
    end

    // Sample both ports in the cycle before pad_clk rises
    always_ff @(posedge clk_2x) begin
        if (state == st_clk_low && phase_done) begin
            shift0.raw <= {pad_data0, shift0.raw[pad_bits-1:1]};
            shift1.raw <= {pad_data1, shift1.raw[pad_bits-1:1]};
        end
    end

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            state      <= st_idle;
            phase_cnt  <= '0;
            bit_cnt    <= '0;
            pad_latch  <= 1'b0;
            pad_clk    <= 1'b0;
            pad_valid  <= 1'b0;
            pad_state0 <= '0;
            pad_state1 <= '0;
            led_r      <= 1'b0;
            led_b      <= 1'b0;
        end else begin
            pad_valid <= 1'b0;
            phase_cnt <= phase_done ? '0 : phase_cnt + 1'b1;
            case (state)
                st_idle: begin
                    phase_cnt <= '0;
                    if (poll_cnt == poll_w'(POLL_CYCLES - 1)) begin
                        state     <= st_latch;
                        pad_latch <= 1'b1;
                    end
                end
                st_latch: begin
                    if (phase_done) begin
                        pad_latch <= 1'b0;
                        bit_cnt   <= '0;
                        state     <= st_clk_low;
                    end
                end
                st_clk_low: begin
                    if (phase_done) begin
                        pad_clk <= 1'b1;
                        state   <= st_clk_high;
                    end
                end
                default: begin
                    if (phase_done) begin
                        pad_clk <= 1'b0;
                        if (bit_cnt == bit_w'(pad_bits - 1)) begin
                            // All twelve bits in, publish active high
                            state          <= st_idle;
                            pad_state0.raw <= ~shift0.raw;
                            pad_state1.raw <= ~shift1.raw;
                            led_r          <= ~&shift0.raw;
                            led_b          <= ~shift1.raw[0];
                            pad_valid      <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= st_clk_low;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* design/pad_board_top.sv */
// Board top level for the controller input path
// Sampler, debounce loop, mock gamepad on port 0, up button on port 1, reader

`timescale 1ns/1ns

module pad_board_top
    import board_pkg::*, pad_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = default_debounce_cycles,
    parameter int PAD_HALF_PERIOD = default_pad_half_period,
    parameter int POLL_CYCLES     = default_poll_cycles
) (
    input  logic      clk_2x,
    input  logic      rst,

    input  logic [2:0] btn,
    input  logic       btn_u,

    output pad_word_t pad_state0,
    output pad_word_t pad_state1,
    output logic      pad_valid,

    output logic      led_r,
    output logic      led_b,

    output logic      pad_latch,
    output logic      pad_clk
);

    logic [num_buttons-1:0] btn_sync;
    logic [num_buttons-1:0] btn_db;
    logic                   pad_data0;
    logic                   pad_data1;

    button_sampler i_button_sampler (
        .clk_2x   (clk_2x),
        .rst      (rst),
        .pins     ({btn_u, btn}),
        .btn_sync (btn_sync)
    );

    for (genvar i = 0; i < num_buttons; i++) begin : g_debounce
        button_debounce #(
            .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) i_button_debounce (
            .clk_2x  (clk_2x),
            .rst     (rst),
            .btn_in  (btn_sync[i]),
            .btn_out (btn_db[i])
        );
    end

    // Only the three board buttons reach the mock pad
    mock_gamepad i_mock_gamepad (
        .clk_2x    (clk_2x),
        .rst       (rst),
        .pad_clk   (pad_clk),
        .pad_latch (pad_latch),
        .pad_btn   (btn_db[2:0]),
        .pad_out   (pad_data0)
    );

    // Up button holds port 1 low while pressed
    assign pad_data1 = ~btn_db[btn_up_index];

    gamepad_reader #(
        .PAD_HALF_PERIOD (PAD_HALF_PERIOD),
        .POLL_CYCLES     (POLL_CYCLES)
    ) i_gamepad_reader (
        .clk_2x     (clk_2x),
        .rst        (rst),
        .pad_data0  (pad_data0),
        .pad_data1  (pad_data1),
        .pad_latch  (pad_latch),
        .pad_clk    (pad_clk),
        .pad_state0 (pad_state0),
        .pad_state1 (pad_state1),
        .pad_valid  (pad_valid),
        .led_r      (led_r),
        .led_b      (led_b)
    );

endmodule

/* tests/pad_assertions.sv */
// Serial gamepad protocol assertions
// Bound into every gamepad_reader instance

`timescale 1ns/1ns

module pad_assertions
    import pad_pkg::*;
(
    input logic clk_2x,
    input logic rst,
    input logic pad_latch,
    input logic pad_clk,
    input logic pad_valid
);

    logic [$clog2(pad_bits+1)-1:0] clk_rises;
    logic                          pad_clk_q;

    // Failed assertions so far
    int error_count = 0;

    // Rises of pad_clk since the last latch pulse
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_clk_q <= 1'b0;
            clk_rises <= '0;
        end else begin
            pad_clk_q <= pad_clk;
            if (pad_latch) begin
                clk_rises <= '0;
            end else if (pad_clk && !pad_clk_q) begin
                clk_rises <= clk_rises + 1'b1;
            end
        end
    end

    latch_clk_exclusive: assert property (
        @(posedge clk_2x) disable iff (rst) !(pad_latch && pad_clk)
    ) else begin
        error_count++;
        $error("pad_latch and pad_clk are high in the same cycle");
    end

    valid_single_cycle: assert property (
        @(posedge clk_2x) disable iff (rst) pad_valid |=> !pad_valid
    ) else begin
        error_count++;
        $error("pad_valid stayed high for more than one cycle");
    end

    // A full read is one clock pulse per word bit
    clocks_per_read: assert property (
        @(posedge clk_2x) disable iff (rst) pad_valid |-> clk_rises == pad_bits
    ) else begin
        error_count++;
        $error("pad_valid after %0d pad_clk rises", clk_rises);
    end

endmodule

bind gamepad_reader pad_assertions i_pad_assertions (
    .clk_2x    (clk_2x),
    .rst       (rst),
    .pad_latch (pad_latch),
    .pad_clk   (pad_clk),
    .pad_valid (pad_valid)
);

/* tests/pad_checker.sv */
// Watcher for the published pad state, LEDs and serial pulse widths
// Compares each pad_valid against the expected values, counts misses

`timescale 1ns/1ns

module pad_checker
    import pad_pkg::*;
#(
    parameter int PAD_HALF_PERIOD = 2,
    parameter int POLL_CYCLES     = 96
) (
    input  logic      clk_2x,
    input  logic      rst,
    input  logic      pad_latch,
    input  logic      pad_clk,
    input  logic      pad_valid,
    input  pad_word_t pad_state0,
    input  pad_word_t pad_state1,
    input  logic      led_r,
    input  logic      led_b,
    input  pad_word_t exp_state0,
    input  pad_word_t exp_state1,
    input  logic      exp_led_r,
    input  logic      exp_led_b,
    output int        mismatch_count,
    output int        timeout_count,
    output int        check_count
);

    // Two polls are enough for any level to reach a published word
    localparam int settle_cycles = 2 * POLL_CYCLES;

    logic [2*pad_bits+1:0] exp_all;
    logic [2*pad_bits+1:0] exp_prev;
    int                    stable_cnt = 0;

    // Pulse widths of the latch and the clock, in cycles
    int latch_len = 0;
    int high_len  = 0;
    int low_len   = 0;

    assign exp_all = {exp_state0.raw, exp_state1.raw, exp_led_r, exp_led_b};

    always @(negedge clk_2x) begin
        exp_prev <= exp_all;
        if (rst || exp_all != exp_prev) begin
            stable_cnt <= 0;
        end else if (stable_cnt < settle_cycles) begin
            stable_cnt <= stable_cnt + 1;
        end
    end

    task automatic compare_value(input string name, input logic [pad_bits-1:0] got,
                                 input logic [pad_bits-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("[ERROR] %s got 0x%03h expected 0x%03h", name, got, exp);
        end
    endtask

    // Latch pulse, clock high and clock low each last one half period
    always @(negedge clk_2x) begin
        if (rst || pad_latch || pad_clk) begin
            low_len <= 0;
        end else begin
            low_len <= low_len + 1;
        end
        latch_len <= pad_latch ? latch_len + 1 : 0;
        high_len  <= pad_clk ? high_len + 1 : 0;
        if (!rst) begin
            if (!pad_latch && latch_len != 0) begin
                compare_value("pad_latch width", 12'(latch_len), 12'(PAD_HALF_PERIOD));
            end
            if (!pad_clk && high_len != 0) begin
                compare_value("pad_clk high width", 12'(high_len), 12'(PAD_HALF_PERIOD));
            end
            if (pad_clk && high_len == 0) begin
                compare_value("pad_clk low width", 12'(low_len), 12'(PAD_HALF_PERIOD));
            end
        end
    end

    initial begin
        int   waited;
        logic seen;
        mismatch_count = 0;
        timeout_count  = 0;
        check_count    = 0;
        waited         = 0;
        while (rst !== 1'b0 && waited < settle_cycles) begin
            @(negedge clk_2x);
            waited++;
        end
        if (rst !== 1'b0) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        forever begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < settle_cycles) begin
                @(negedge clk_2x);
                waited++;
                seen = (pad_valid === 1'b1);
            end
            if (!seen) begin
                timeout_count++;
                $display("Timeout: no pad_valid within %0d cycles", settle_cycles);
            end else if (stable_cnt >= settle_cycles && exp_all == exp_prev) begin
                check_count++;
                compare_value("pad_state0", pad_state0.raw, exp_state0.raw);
                compare_value("pad_state1", pad_state1.raw, exp_state1.raw);
                compare_value("led_r", 12'(led_r), 12'(exp_led_r));
                compare_value("led_b", 12'(led_b), 12'(exp_led_b));
            end
        end
    end

endmodule

/* tests/tb_pad_board.sv */
// Testbench for the pad board top level
// Clock, reset, button stimulus, reference pad words, closing summary

`timescale 1ns/1ns

module tb_pad_board
    import pad_pkg::*;
();

    localparam int debounce_cycles = 8;
    localparam int pad_half_period = 2;
    localparam int poll_cycles     = 96;

    logic       clk_2x = 1'b0;
    logic       rst;
    logic [2:0] btn;
    logic       btn_u;
    pad_word_t  pad_state0;
    pad_word_t  pad_state1;
    logic       pad_valid;
    logic       led_r;
    logic       led_b;
    logic       pad_latch;
    logic       pad_clk;

    // Levels meant to be held, short pulses left out
    logic [2:0] held_btn;
    logic       held_up;
    pad_word_t  exp_state0;
    pad_word_t  exp_state1;
    logic       exp_led_r;
    logic       exp_led_b;

    int mismatch_count;
    int timeout_count;
    int check_count;
    int wait_timeouts;
    int assert_errors;

    always #5 clk_2x = ~clk_2x;

    function automatic pad_word_t expected_state0(input logic [2:0] held);
        pad_word_t word;
        word                    = '0;
        word.raw[pad_bit_a]     = held[0];
        word.raw[pad_bit_b]     = held[1];
        word.raw[pad_bit_start] = held[2];
        return word;
    endfunction

    // Port 1 reads low on every bit while up is held
    function automatic pad_word_t expected_state1(input logic up);
        pad_word_t word;
        word.raw = {pad_bits{up}};
        return word;
    endfunction

    assign exp_state0 = expected_state0(held_btn);
    assign exp_state1 = expected_state1(held_up);
    assign exp_led_r  = |exp_state0.raw;
    assign exp_led_b  = exp_state1.btn.b;

    pad_board_top #(
        .DEBOUNCE_CYCLES (debounce_cycles),
        .PAD_HALF_PERIOD (pad_half_period),
        .POLL_CYCLES     (poll_cycles)
    ) i_pad_board_top (
        .clk_2x     (clk_2x),
        .rst        (rst),
        .btn        (btn),
        .btn_u      (btn_u),
        .pad_state0 (pad_state0),
        .pad_state1 (pad_state1),
        .pad_valid  (pad_valid),
        .led_r      (led_r),
        .led_b      (led_b),
        .pad_latch  (pad_latch),
        .pad_clk    (pad_clk)
    );

    pad_checker #(
        .PAD_HALF_PERIOD (pad_half_period),
        .POLL_CYCLES     (poll_cycles)
    ) i_pad_checker (
        .clk_2x         (clk_2x),
        .rst            (rst),
        .pad_latch      (pad_latch),
        .pad_clk        (pad_clk),
        .pad_valid      (pad_valid),
        .pad_state0     (pad_state0),
        .pad_state1     (pad_state1),
        .led_r          (led_r),
        .led_b          (led_b),
        .exp_state0     (exp_state0),
        .exp_state1     (exp_state1),
        .exp_led_r      (exp_led_r),
        .exp_led_b      (exp_led_b),
        .mismatch_count (mismatch_count),
        .timeout_count  (timeout_count),
        .check_count    (check_count)
    );

    task automatic hold_buttons(input logic [2:0] pressed, input logic up);
        @(posedge clk_2x);
        #1;
        btn      = pressed;
        btn_u    = up;
        held_btn = pressed;
        held_up  = up;
    endtask

    task automatic wait_valid_pulses(input int count);
        int   k;
        int   waited;
        logic seen;
        for (k = 0; k < count; k++) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < 2 * poll_cycles) begin
                @(negedge clk_2x);
                waited++;
                seen = (pad_valid === 1'b1);
            end
            if (!seen) begin
                wait_timeouts++;
                $display("Timeout: stimulus saw no pad_valid for %0d cycles", 2 * poll_cycles);
            end
        end
    endtask

    // Pulses one cycle shorter than the debounce window at most
    task automatic send_glitches(input int count);
        int n;
        int pin;
        int width;
        int gap;
        for (n = 0; n < count; n++) begin
            pin   = $urandom_range(0, 3);
            width = $urandom_range(1, debounce_cycles - 1);
            gap   = $urandom_range(1, 12);
            @(posedge clk_2x);
            #1;
            if (pin == 3) begin
                btn_u = ~held_up;
            end else begin
                btn[pin] = ~held_btn[pin];
            end
            repeat (width) @(posedge clk_2x);
            #1;
            btn   = held_btn;
            btn_u = held_up;
            repeat (gap) @(posedge clk_2x);
        end
    endtask

    initial begin
        logic [2:0] combo;
        int         i;
        void'($urandom(32'hed3));
        rst           = 1'b1;
        btn           = 3'b000;
        btn_u         = 1'b0;
        held_btn      = 3'b000;
        held_up       = 1'b0;
        wait_timeouts = 0;
        assert_errors = 0;
        repeat (5) @(posedge clk_2x);
        #1;
        rst = 1'b0;

        // Idle pad reads as all released
        wait_valid_pulses(4);

        for (i = 0; i < 3; i++) begin
            hold_buttons(3'(1 << i), 1'b0);
            wait_valid_pulses(4);
        end
        hold_buttons(3'b000, 1'b0);
        wait_valid_pulses(3);

        repeat (6) begin
            combo = 3'($urandom_range(0, 7));
            hold_buttons(combo, 1'b0);
            wait_valid_pulses(4);
        end

        // Up button on port 1 must not disturb port 0
        hold_buttons(3'b010, 1'b0);
        wait_valid_pulses(3);
        hold_buttons(3'b010, 1'b1);
        wait_valid_pulses(4);
        hold_buttons(3'b000, 1'b1);
        wait_valid_pulses(4);
        hold_buttons(3'b101, 1'b0);
        wait_valid_pulses(4);

        send_glitches(60);
        hold_buttons(3'b000, 1'b0);
        wait_valid_pulses(3);
        send_glitches(60);
        wait_valid_pulses(2);

        assert_errors = i_pad_board_top.i_gamepad_reader.i_pad_assertions.error_count;
        if (check_count == 0) begin
            $display("No published pad state was compared with the reference");
        end
        $display(
            "Errors: %0d mismatch, %0d timeout, %0d wait timeout, %0d assertion; %0d checks",
            mismatch_count, timeout_count, wait_timeouts, assert_errors, check_count);
        if (mismatch_count + timeout_count + wait_timeouts + assert_errors == 0
            && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/board_pkg.sv
design/pad_pkg.sv
design/button_sampler.sv
design/button_debounce.sv
design/mock_gamepad.sv
design/gamepad_reader.sv
design/pad_board_top.sv
tests/pad_assertions.sv
tests/pad_checker.sv
tests/tb_pad_board.sv

/* Bender.yml */
package:
  name: pad_board

sources:
  - design/board_pkg.sv
  - design/pad_pkg.sv
  - design/button_sampler.sv
  - design/button_debounce.sv
  - design/mock_gamepad.sv
  - design/gamepad_reader.sv
  - design/pad_board_top.sv
  - target: test
    files:
      - tests/pad_assertions.sv
      - tests/pad_checker.sv
      - tests/tb_pad_board.sv
